// ==== common/xm23Pkg.sv ====
package xm23Pkg;

	localparam int wordWidth = 16;

	// Opcode numbers as produced by the decoder
	typedef enum logic [5:0] {
		opBl         = 6'd0,
		opBeq        = 6'd1,
		opBne        = 6'd2,
		opBc         = 6'd3,
		opBnc        = 6'd4,
		opBn         = 6'd5,
		opBge        = 6'd6,
		opBlt        = 6'd7,
		opBra        = 6'd8,
		opAdd        = 6'd9,
		opAddc       = 6'd10,
		opSub        = 6'd11,
		opSubc       = 6'd12,
		opDadd       = 6'd13,
		opCmp        = 6'd14,
		opXor        = 6'd15,
		opAnd        = 6'd16,
		opOr         = 6'd17,
		opBit        = 6'd18,
		opBic        = 6'd19,
		opBis        = 6'd20,
		opMov        = 6'd21,
		opSwap       = 6'd22,
		opSra        = 6'd23,
		opRrc        = 6'd24,
		opSwpb       = 6'd25,
		opSxt        = 6'd26,
		opSetpri     = 6'd28,
		opSvc        = 6'd29,
		opSetcc      = 6'd30,
		opClrcc      = 6'd31,
		opCex        = 6'd32,
		opLd         = 6'd33,
		opSt         = 6'd34,
		opMovl       = 6'd35,
		opMovlz      = 6'd36,
		opMovls      = 6'd37,
		opMovh       = 6'd38,
		opLdr        = 6'd39,
		opStr        = 6'd40,
		opBreakpoint = 6'd41,
		opReserved   = 6'd63	// Unassigned encodings
	} opcodeT;

	typedef enum logic [1:0] {
		noFault      = 2'd0,
		invalidInstr = 2'd1,
		unsupported  = 2'd2
	} faultT;

	// Constants selected by the source field when rc is set
	localparam logic [wordWidth-1:0] constTable [0:7] = '{
		16'h0000, 16'h0001, 16'h0002, 16'h0004,
		16'h0008, 16'h0010, 16'h0020, 16'hFFFF
	};

	// Flag positions, matching the low four bits of pswBits
	localparam int pswCarry    = 0;
	localparam int pswZero     = 1;
	localparam int pswNegative = 2;
	localparam int pswOverflow = 3;

endpackage

// ==== decode/instructionDecoder.sv ====
`timescale 1ns/1ns

module instructionDecoder (
	input  logic                Clock,
	input  logic                reset,
	input  logic [15:0]         instr,
	input  logic                instrValid,
	output logic                decValid,
	output xm23Pkg::opcodeT     opcode,
	output logic [2:0]          srcCon,
	output logic [2:0]          dst,
	output logic                rc,
	output logic                wb,
	output logic [7:0]          imByte,
	output logic [4:0]          pswBits,
	output logic                decFault
);

	xm23Pkg::opcodeT nextOpcode;
	logic            nextFault;
	logic            nextRc;

	// Opcode number from the top three bits and the sub-fields below them
	always_comb begin
		nextOpcode = xm23Pkg::opReserved;
		nextFault = 1'b0;
		nextRc = 1'b0;
		case (instr[15:13])
			3'd0: nextOpcode = xm23Pkg::opBl;
			3'd1: nextOpcode = xm23Pkg::opcodeT'(6'd1 + 6'(instr[12:10]));	// BEQ to BRA
			3'd2: begin
				case (instr[12:10])
					3'd0, 3'd1, 3'd2: begin
						nextRc = instr[7];	// Only the two-operand group has R/C
						case (instr[11:8])
							4'd0:    nextOpcode = xm23Pkg::opAdd;
							4'd1:    nextOpcode = xm23Pkg::opAddc;
							4'd2:    nextOpcode = xm23Pkg::opSub;
							4'd3:    nextOpcode = xm23Pkg::opSubc;
							4'd4:    nextOpcode = xm23Pkg::opDadd;
							4'd5:    nextOpcode = xm23Pkg::opCmp;
							4'd6:    nextOpcode = xm23Pkg::opXor;
							4'd7:    nextOpcode = xm23Pkg::opAnd;
							4'd8:    nextOpcode = xm23Pkg::opOr;
							4'd9:    nextOpcode = xm23Pkg::opBit;
							4'd10:   nextOpcode = xm23Pkg::opBic;
							default: nextOpcode = xm23Pkg::opBis;	// Only 11 is left here
						endcase
					end
					3'd3: begin
						case (instr[9:7])
							3'd0: nextOpcode = xm23Pkg::opMov;
							3'd1: nextOpcode = xm23Pkg::opSwap;
							3'd2: begin
								if (instr[5:3] < 3'd4)	// SRA, RRC, SWPB, SXT
									nextOpcode = xm23Pkg::opcodeT'(6'd23 + 6'(instr[5:3]));
							end
							3'd3: nextOpcode = xm23Pkg::opcodeT'(6'd28 + 6'(instr[6:5]));
							default: nextOpcode = xm23Pkg::opReserved;
						endcase
					end
					3'd4: nextOpcode = xm23Pkg::opCex;
					3'd5: begin
						if (instr[9:0] == 10'd0)
							nextOpcode = xm23Pkg::opBreakpoint;
						else
							nextFault = 1'b1;	// The one invalid encoding group
					end
					default: begin
						if (instr[12:10] == 3'd6)
							nextOpcode = xm23Pkg::opLd;
						else
							nextOpcode = xm23Pkg::opSt;
					end
				endcase
			end
			3'd3: begin
				case (instr[12:11])
					2'd0:    nextOpcode = xm23Pkg::opMovl;
					2'd1:    nextOpcode = xm23Pkg::opMovlz;
					2'd2:    nextOpcode = xm23Pkg::opMovls;
					default: nextOpcode = xm23Pkg::opMovh;
				endcase
			end
			default: begin
				if (instr[15:14] == 2'b11)
					nextOpcode = xm23Pkg::opStr;
				else
					nextOpcode = xm23Pkg::opLdr;
			end
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			decValid <= 1'b0;
			decFault <= 1'b0;
		end else begin
			decValid <= instrValid;
			decFault <= instrValid & nextFault;
		end
	end

	// Fields are captured raw on every strobe
	always_ff @(posedge Clock) begin
		if (instrValid) begin
			opcode <= nextOpcode;
			srcCon <= instr[5:3];
			dst <= instr[2:0];
			rc <= nextRc;
			wb <= instr[6];
			imByte <= instr[10:3];
			pswBits <= instr[4:0];
		end
	end

endmodule

// ==== execute/registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
	input  logic                           Clock,
	input  logic                           reset,
	input  logic [2:0]                     rdAddrA,
	input  logic [2:0]                     rdAddrB,
	output logic [xm23Pkg::wordWidth-1:0]  rdDataA,
	output logic [xm23Pkg::wordWidth-1:0]  rdDataB,
	input  logic                           wrEn,
	input  logic [2:0]                     wrAddr,
	input  logic [xm23Pkg::wordWidth-1:0]  wrData,
	input  logic                           wrByte
);

	logic [xm23Pkg::wordWidth-1:0] regs [0:7];

	assign rdDataA = regs[rdAddrA];	// Asynchronous reads
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge Clock) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			if (wrByte)
				regs[wrAddr][7:0] <= wrData[7:0];	// High byte untouched
			else
				regs[wrAddr] <= wrData;
		end
	end

endmodule

// ==== execute/executeUnit.sv ====
`timescale 1ns/1ns

module executeUnit (
	input  logic                           Clock,
	input  logic                           reset,
	input  logic                           decValid,
	input  xm23Pkg::opcodeT                opcode,
	input  logic [2:0]                     srcCon,
	input  logic [2:0]                     dst,
	input  logic                           rc,
	input  logic                           wb,
	input  logic [7:0]                     imByte,
	input  logic [4:0]                     pswBits,
	input  logic                           decFault,
	output logic [2:0]                     rdAddrA,
	output logic [2:0]                     rdAddrB,
	input  logic [xm23Pkg::wordWidth-1:0]  rdDataA,
	input  logic [xm23Pkg::wordWidth-1:0]  rdDataB,
	input  logic [3:0]                     psw,
	output logic                           exValid,
	output logic [2:0]                     exDst,
	output logic [xm23Pkg::wordWidth-1:0]  exValue,
	output logic                           exWrite,
	output logic                           exByte,
	output logic [3:0]                     exPsw,
	output logic                           exPswWrite,
	output xm23Pkg::faultT                 exFault
);

	logic [xm23Pkg::wordWidth-1:0] srcOp, dstOp, addend, logicRaw, shifted, opValue;
	logic [xm23Pkg::wordWidth:0]   sumWord;
	logic [8:0]                    sumByte;
	logic [3:0]                    curPsw, newPsw;
	logic                          carryIn, shiftIn, doWrite, doPsw, setZn, byteNext;
	xm23Pkg::faultT                faultNext;

	function automatic logic signBit(input logic [15:0] v, input logic byteMode);
		return byteMode ? v[7] : v[15];
	endfunction

	function automatic logic isZero(input logic [15:0] v, input logic byteMode);
		return byteMode ? (v[7:0] == 8'd0) : (v == 16'd0);
	endfunction

	// Byte results keep the destination's high byte
	function automatic logic [15:0] mergeWidth(input logic [15:0] old, input logic [15:0] raw,
			input logic byteMode);
		return byteMode ? {old[15:8], raw[7:0]} : raw;
	endfunction

	assign rdAddrA = srcCon;
	assign rdAddrB = dst;

	// Previous instruction is still in the execute register
	assign srcOp = rc ? xm23Pkg::constTable[srcCon] :
		((exValid && exWrite && exDst == srcCon) ? exValue : rdDataA);
	assign dstOp = (exValid && exWrite && exDst == dst) ? exValue : rdDataB;
	assign curPsw = (exValid && exPswWrite) ? exPsw : psw;

	always_comb begin
		addend = srcOp;
		carryIn = 1'b0;
		case (opcode)
			xm23Pkg::opAddc: carryIn = curPsw[xm23Pkg::pswCarry];
			xm23Pkg::opSub, xm23Pkg::opCmp: begin
				addend = ~srcOp;
				carryIn = 1'b1;
			end
			xm23Pkg::opSubc: begin
				addend = ~srcOp;
				carryIn = curPsw[xm23Pkg::pswCarry];
			end
			default: carryIn = 1'b0;
		endcase
	end

	assign sumWord = {1'b0, dstOp} + {1'b0, addend} + {16'd0, carryIn};
	assign sumByte = {1'b0, dstOp[7:0]} + {1'b0, addend[7:0]} + {8'd0, carryIn};

	assign shiftIn = (opcode == xm23Pkg::opRrc) ? curPsw[xm23Pkg::pswCarry] : signBit(dstOp, wb);
	assign shifted = wb ? {8'h00, shiftIn, dstOp[7:1]} : {shiftIn, dstOp[15:1]};

	always_comb begin
		case (opcode)
			xm23Pkg::opXor:                 logicRaw = dstOp ^ srcOp;
			xm23Pkg::opAnd, xm23Pkg::opBit: logicRaw = dstOp & srcOp;
			xm23Pkg::opOr, xm23Pkg::opBis:  logicRaw = dstOp | srcOp;
			default:                        logicRaw = dstOp & ~srcOp;	// BIC
		endcase
	end

	always_comb begin
		opValue = dstOp;
		newPsw = curPsw;
		doWrite = 1'b0;
		doPsw = 1'b0;
		setZn = 1'b0;
		byteNext = 1'b0;
		faultNext = xm23Pkg::noFault;
		if (decFault) begin
			faultNext = xm23Pkg::invalidInstr;
		end else begin
			case (opcode)
				xm23Pkg::opAdd, xm23Pkg::opAddc, xm23Pkg::opSub, xm23Pkg::opSubc,
				xm23Pkg::opCmp: begin
					opValue = mergeWidth(dstOp, sumWord[15:0], wb);
					newPsw[xm23Pkg::pswCarry] = wb ? sumByte[8] : sumWord[16];
					newPsw[xm23Pkg::pswOverflow] = (signBit(dstOp, wb) == signBit(addend, wb)) &&
						(signBit(opValue, wb) != signBit(dstOp, wb));
					doWrite = (opcode != xm23Pkg::opCmp);
					{doPsw, setZn, byteNext} = {1'b1, 1'b1, wb};
				end
				xm23Pkg::opXor, xm23Pkg::opAnd, xm23Pkg::opOr, xm23Pkg::opBit,
				xm23Pkg::opBic, xm23Pkg::opBis: begin
					opValue = mergeWidth(dstOp, logicRaw, wb);
					newPsw[xm23Pkg::pswOverflow] = 1'b0;	// Carry kept
					doWrite = (opcode != xm23Pkg::opBit);
					{doPsw, setZn, byteNext} = {1'b1, 1'b1, wb};
				end
				xm23Pkg::opSra, xm23Pkg::opRrc: begin
					opValue = mergeWidth(dstOp, shifted, wb);
					newPsw[xm23Pkg::pswCarry] = dstOp[0];	// Shifted-out bit
					newPsw[xm23Pkg::pswOverflow] = 1'b0;
					doWrite = 1'b1;
					{doPsw, setZn, byteNext} = {1'b1, 1'b1, wb};
				end
				xm23Pkg::opMov: begin
					opValue = mergeWidth(dstOp, srcOp, wb);
					doWrite = 1'b1;
					byteNext = wb;
				end
				xm23Pkg::opSwpb: {opValue, doWrite} = {dstOp[7:0], dstOp[15:8], 1'b1};
				xm23Pkg::opSxt:  {opValue, doWrite} = {{8{dstOp[7]}}, dstOp[7:0], 1'b1};
				xm23Pkg::opMovl:  {opValue, doWrite} = {dstOp[15:8], imByte, 1'b1};
				xm23Pkg::opMovlz: {opValue, doWrite} = {8'h00, imByte, 1'b1};
				xm23Pkg::opMovls: {opValue, doWrite} = {8'hFF, imByte, 1'b1};
				xm23Pkg::opMovh:  {opValue, doWrite} = {imByte, dstOp[7:0], 1'b1};
				xm23Pkg::opSetcc: {newPsw, doPsw} = {curPsw | pswBits[3:0], 1'b1};
				xm23Pkg::opClrcc: {newPsw, doPsw} = {curPsw & ~pswBits[3:0], 1'b1};
				default: faultNext = xm23Pkg::unsupported;
			endcase
			if (setZn) begin
				newPsw[xm23Pkg::pswZero] = isZero(opValue, byteNext);
				newPsw[xm23Pkg::pswNegative] = signBit(opValue, byteNext);
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			exValid <= 1'b0;
			exFault <= xm23Pkg::noFault;
		end else begin
			exValid <= decValid;
			exFault <= decValid ? faultNext : xm23Pkg::noFault;
		end
	end

	// exValue is always the destination's full content after this instruction
	always_ff @(posedge Clock) begin
		if (decValid) begin
			exDst <= dst;
			exValue <= doWrite ? opValue : dstOp;
			exWrite <= doWrite;
			exByte <= byteNext;
			exPsw <= newPsw;
			exPswWrite <= doPsw;
		end
	end

endmodule

// ==== rtl/resultStage.sv ====
`timescale 1ns/1ns

module resultStage (
	input  logic                           Clock,
	input  logic                           reset,
	input  logic                           exValid,
	input  logic [2:0]                     exDst,
	input  logic [xm23Pkg::wordWidth-1:0]  exValue,
	input  logic                           exWrite,
	input  logic                           exByte,
	input  logic [3:0]                     exPsw,
	input  logic                           exPswWrite,
	input  xm23Pkg::faultT                 exFault,
	output logic                           wrEn,
	output logic [2:0]                     wrAddr,
	output logic [xm23Pkg::wordWidth-1:0]  wrData,
	output logic                           wrByte,
	output logic [3:0]                     psw,
	output logic                           resultValid,
	output logic [2:0]                     resultDst,
	output logic [xm23Pkg::wordWidth-1:0]  resultValue,
	output logic                           resultWritten,
	output xm23Pkg::faultT                 fault
);

	// Write lands on the edge that ends the exValid cycle
	assign wrEn = exValid && exWrite;
	assign wrAddr = exDst;
	assign wrData = exValue;
	assign wrByte = exByte;

	always_ff @(posedge Clock) begin
		if (reset) begin
			psw <= 4'd0;
			resultValid <= 1'b0;
			fault <= xm23Pkg::noFault;
		end else begin
			resultValid <= exValid;
			fault <= exFault;
			if (exValid && exPswWrite)
				psw <= exPsw;
		end
	end

	always_ff @(posedge Clock) begin
		if (exValid) begin
			resultDst <= exDst;
			resultValue <= exValue;	// Already merged with the old high byte
			resultWritten <= exWrite;
		end
	end

endmodule

// ==== rtl/xm23Core.sv ====
`timescale 1ns/1ns

module xm23Core (
	input  logic                           Clock,
	input  logic                           reset,
	input  logic [15:0]                    instr,
	input  logic                           instrValid,
	output logic                           resultValid,
	output logic [2:0]                     resultDst,
	output logic [xm23Pkg::wordWidth-1:0]  resultValue,
	output logic                           resultWritten,
	output logic [3:0]                     psw,
	output xm23Pkg::faultT                 fault
);

	logic                          decValid, rc, wb, decFault;
	xm23Pkg::opcodeT               opcode;
	logic [2:0]                    srcCon, dst;
	logic [7:0]                    imByte;
	logic [4:0]                    pswBits;
	logic [2:0]                    rdAddrA, rdAddrB, exDst, wrAddr;
	logic [xm23Pkg::wordWidth-1:0] rdDataA, rdDataB, exValue, wrData;
	logic                          exValid, exWrite, exByte, exPswWrite, wrEn, wrByte;
	logic [3:0]                    exPsw;
	xm23Pkg::faultT                exFault;

	instructionDecoder decoder_i (
		.Clock, .reset, .instr, .instrValid, .decValid, .opcode, .srcCon, .dst,
		.rc, .wb, .imByte, .pswBits, .decFault
	);

	executeUnit execute_i (
		.Clock, .reset, .decValid, .opcode, .srcCon, .dst, .rc, .wb, .imByte,
		.pswBits, .decFault, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB, .psw,
		.exValid, .exDst, .exValue, .exWrite, .exByte, .exPsw, .exPswWrite, .exFault
	);

	registerFile registers_i (
		.Clock, .reset, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
		.wrEn, .wrAddr, .wrData, .wrByte
	);

	// Also the PSW source for execute
	resultStage result_i (
		.Clock, .reset, .exValid, .exDst, .exValue, .exWrite, .exByte, .exPsw,
		.exPswWrite, .exFault, .wrEn, .wrAddr, .wrData, .wrByte, .psw,
		.resultValid, .resultDst, .resultValue, .resultWritten, .fault
	);

endmodule

// ==== testbench/xm23CoreAssertions.sv ====
`timescale 1ns/1ns

module xm23CoreAssertions (
	input logic           Clock,
	input logic           reset,
	input logic           instrValid,
	input logic           decValid,
	input logic           exValid,
	input logic           resultValid,
	input xm23Pkg::faultT fault
);

	// Fixed three-stage latency, checked both ways
	assert property (@(posedge Clock) disable iff (reset) instrValid |-> ##3 resultValid)
		else $error("Instruction did not retire three cycles after issue");

	assert property (@(posedge Clock) disable iff (reset) resultValid |-> $past(instrValid, 3))
		else $error("Retire without an instruction three cycles earlier");

	assert property (@(posedge Clock)
			reset |=> !(decValid || exValid || resultValid) && fault == xm23Pkg::noFault)
		else $error("Pipeline strobe active during reset");

	assert property (@(posedge Clock) $fell(reset) |=> !(exValid || resultValid))
		else $error("Pipeline strobe active in the cycle after reset");

	assert property (@(posedge Clock) disable iff (reset)
			fault != xm23Pkg::noFault |-> resultValid)
		else $error("Fault reported without a retire");

endmodule

bind xm23Core xm23CoreAssertions assertions_i (
	.Clock, .reset, .instrValid, .decValid, .exValid, .resultValid, .fault
);

// ==== testbench/xm23CoreTb.sv ====
`timescale 1ns/1ns

module xm23CoreTb;

	typedef struct packed {
		logic [2:0]     dst;
		logic [15:0]    value;
		logic           written;
		logic [3:0]     psw;
		xm23Pkg::faultT fault;
	} retireT;

	logic                 Clock, reset, instrValid;
	logic [15:0]          instr;
	logic                 resultValid, resultWritten;
	logic [2:0]           resultDst;
	logic [15:0]          resultValue;
	logic [3:0]           psw;
	xm23Pkg::faultT       fault;

	logic [15:0] mRegs [0:7] = '{default: 16'h0000};	// Reference model state
	logic [3:0]  mPsw = 4'h0;
	logic [31:0] rngState = 32'd38187;
	logic [15:0] lastValue;
	retireT      expQ [$];
	retireT      gotQ [$];
	retireT      observed;
	int          errors = 0, checks = 0, tests = 0, lastErrors = 0;

	xm23Core dut_i (
		.Clock, .reset, .instr, .instrValid, .resultValid, .resultDst,
		.resultValue, .resultWritten, .psw, .fault
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	// Every retire is queued in order
	always @(negedge Clock) begin
		if (resultValid) begin
			observed.dst = resultDst;
			observed.value = resultValue;
			observed.written = resultWritten;
			observed.psw = psw;
			observed.fault = fault;
			gotQ.push_back(observed);
		end
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic int unsignedOf(input logic [15:0] v, input logic wb);
		return wb ? int'(v[7:0]) : int'(v);
	endfunction

	function automatic int signedOf(input logic [15:0] v, input logic wb);
		return wb ? int'($signed(v[7:0])) : int'($signed(v));
	endfunction

	function automatic logic [15:0] encode(input xm23Pkg::opcodeT op, input logic rc,
			input logic wb, input logic [2:0] s, input logic [2:0] d, input logic [7:0] imm);
		case (op)
			xm23Pkg::opBl:       return {13'd0, d};
			xm23Pkg::opLd:       return {6'b010110, 4'd0, s, d};
			xm23Pkg::opReserved: return {6'b010101, 1'b1, 3'd0, s, d};	// Undefined group-5 word
			xm23Pkg::opMov:      return {9'b010011000, wb, s, d};
			xm23Pkg::opSra, xm23Pkg::opRrc, xm23Pkg::opSwpb, xm23Pkg::opSxt:
				return {9'b010011010, wb, 3'(op - xm23Pkg::opSra), d};
			xm23Pkg::opSetcc:    return {9'b010011011, 2'b10, 1'b0, imm[3:0]};
			xm23Pkg::opClrcc:    return {9'b010011011, 2'b11, 1'b0, imm[3:0]};
			xm23Pkg::opMovl, xm23Pkg::opMovlz, xm23Pkg::opMovls, xm23Pkg::opMovh:
				return {3'b011, 2'(op - xm23Pkg::opMovl), imm, d};
			default:             return {4'b0100, 4'(op - xm23Pkg::opAdd), rc, wb, s, d};
		endcase
	endfunction

	task automatic predict(input xm23Pkg::opcodeT op, input logic rc, input logic wb,
			input logic [2:0] s, input logic [2:0] d, input logic [7:0] imm);
		logic [15:0] a, b, r, addend, raw;
		logic [3:0]  f;
		logic        shiftIn, setZn;
		int          msb, carryIn, total;
		retireT      e;
		a = rc ? xm23Pkg::constTable[s] : mRegs[s];
		b = mRegs[d];
		f = mPsw;
		r = b;
		msb = wb ? 7 : 15;
		setZn = 1'b0;
		e.dst = d;
		e.written = 1'b1;
		e.fault = xm23Pkg::noFault;
		case (op)
			xm23Pkg::opAdd, xm23Pkg::opAddc, xm23Pkg::opSub, xm23Pkg::opSubc, xm23Pkg::opCmp: begin
				addend = (op == xm23Pkg::opAdd || op == xm23Pkg::opAddc) ? a : ~a;
				carryIn = f[xm23Pkg::pswCarry];
				if (op == xm23Pkg::opAdd)
					carryIn = 0;
				else if (op == xm23Pkg::opSub || op == xm23Pkg::opCmp)
					carryIn = 1;	// Two's complement subtract
				total = unsignedOf(b, wb) + unsignedOf(addend, wb) + carryIn;
				f[xm23Pkg::pswCarry] = total > (wb ? 255 : 65535);
				total = signedOf(b, wb) + signedOf(addend, wb) + carryIn;
				f[xm23Pkg::pswOverflow] = total > (wb ? 127 : 32767) || total < (wb ? -128 : -32768);
				raw = b + addend + 16'(carryIn);
				r = wb ? {b[15:8], raw[7:0]} : raw;
				e.written = op != xm23Pkg::opCmp;
				setZn = 1'b1;
			end
			xm23Pkg::opXor, xm23Pkg::opAnd, xm23Pkg::opOr, xm23Pkg::opBit, xm23Pkg::opBic,
			xm23Pkg::opBis: begin
				case (op)
					xm23Pkg::opXor:                 raw = b ^ a;
					xm23Pkg::opAnd, xm23Pkg::opBit: raw = b & a;
					xm23Pkg::opBic:                 raw = b & ~a;
					default:                        raw = b | a;
				endcase
				r = wb ? {b[15:8], raw[7:0]} : raw;
				f[xm23Pkg::pswOverflow] = 1'b0;	// Carry untouched
				e.written = op != xm23Pkg::opBit;
				setZn = 1'b1;
			end
			xm23Pkg::opSra, xm23Pkg::opRrc: begin
				shiftIn = (op == xm23Pkg::opRrc) ? f[xm23Pkg::pswCarry] : b[msb];
				r = wb ? {b[15:8], shiftIn, b[7:1]} : {shiftIn, b[15:1]};
				f[xm23Pkg::pswCarry] = b[0];
				f[xm23Pkg::pswOverflow] = 1'b0;
				setZn = 1'b1;
			end
			xm23Pkg::opMov:   r = wb ? {b[15:8], a[7:0]} : a;
			xm23Pkg::opSwpb:  r = {b[7:0], b[15:8]};
			xm23Pkg::opSxt:   r = {{8{b[7]}}, b[7:0]};
			xm23Pkg::opMovl:  r = {b[15:8], imm};
			xm23Pkg::opMovlz: r = {8'h00, imm};
			xm23Pkg::opMovls: r = {8'hFF, imm};
			xm23Pkg::opMovh:  r = {imm, b[7:0]};
			xm23Pkg::opSetcc, xm23Pkg::opClrcc: begin
				f = (op == xm23Pkg::opSetcc) ? (f | imm[3:0]) : (f & ~imm[3:0]);
				e.written = 1'b0;
			end
			default: begin
				e.fault = (op == xm23Pkg::opReserved) ? xm23Pkg::invalidInstr : xm23Pkg::unsupported;
				e.written = 1'b0;
			end
		endcase
		if (setZn) begin
			f[xm23Pkg::pswZero] = wb ? (r[7:0] == 8'd0) : (r == 16'd0);
			f[xm23Pkg::pswNegative] = r[msb];
		end
		if (e.written)
			mRegs[d] = r;
		mPsw = f;
		e.value = mRegs[d];	// Untouched register content when nothing is written
		e.psw = f;
		expQ.push_back(e);
	endtask

	task automatic compareWord(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compareAddr(input string name, input logic [2:0] expected,
			input logic [2:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic compareBit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic comparePsw(input string name, input logic [3:0] expected,
			input logic [3:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic compareFault(input string name, input xm23Pkg::faultT expected,
			input xm23Pkg::faultT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic checkRetires(input int count);
		retireT want, got;
		int     waited;
		repeat (count) begin
			waited = 0;
			while (gotQ.size() == 0 && waited < 10) begin
				@(negedge Clock);
				waited++;
			end
			want = expQ.pop_front();
			if (gotQ.size() == 0) begin
				errors++;
				$display("No instruction retired within 10 cycles at %0t ns", $time);
			end else begin
				got = gotQ.pop_front();
				compareAddr("resultDst", want.dst, got.dst);
				compareWord("resultValue", want.value, got.value);
				compareBit("resultWritten", want.written, got.written);
				comparePsw("psw", want.psw, got.psw);
				compareFault("fault", want.fault, got.fault);
				lastValue = got.value;
			end
		end
	endtask

	task automatic issueOp(input xm23Pkg::opcodeT op, input logic rc, input logic wb,
			input logic [2:0] s, input logic [2:0] d, input logic [7:0] imm);
		logic [15:0] word;
		word = encode(op, rc, wb, s, d, imm);
		predict(op, rc, wb, s, word[2:0], imm);
		@(negedge Clock);
		instr = word;
		instrValid = 1'b1;
	endtask

	task automatic stopIssue();
		@(negedge Clock);
		instrValid = 1'b0;
	endtask

	task automatic runOp(input xm23Pkg::opcodeT op, input logic rc, input logic wb,
			input logic [2:0] s, input logic [2:0] d, input logic [7:0] imm);
		issueOp(op, rc, wb, s, d, imm);
		stopIssue();
		checkRetires(1);
	endtask

	task automatic loadReg(input logic [2:0] r, input logic [15:0] v);
		runOp(xm23Pkg::opMovlz, 1'b0, 1'b0, 3'd0, r, v[7:0]);
		runOp(xm23Pkg::opMovh, 1'b0, 1'b0, 3'd0, r, v[15:8]);
	endtask

	task automatic endTest(input string name);
		$display("Test %s finished with %0d errors", name, errors - lastErrors);
		lastErrors = errors;
		tests++;
	endtask

	task automatic testLoads();
		logic [15:0] v;
		for (int r = 0; r < 8; r++) begin
			v = 16'(nextRand());
			loadReg(3'(r), v);
			compareWord("loaded register", v, lastValue);
		end
		endTest("loads");
	endtask

	task automatic testArith();
		xm23Pkg::opcodeT ops [5] = '{xm23Pkg::opAdd, xm23Pkg::opAddc, xm23Pkg::opSub,
			xm23Pkg::opSubc, xm23Pkg::opCmp};
		for (int i = 0; i < 40; i++)
			runOp(ops[nextRand() % 5], 1'(nextRand()), 1'(nextRand()), 3'(nextRand()),
				3'(nextRand()), 8'd0);
		endTest("arithmetic");
	endtask

	task automatic testLogic();
		xm23Pkg::opcodeT ops [11] = '{xm23Pkg::opXor, xm23Pkg::opAnd, xm23Pkg::opOr,
			xm23Pkg::opBit, xm23Pkg::opBic, xm23Pkg::opBis, xm23Pkg::opMov, xm23Pkg::opSra,
			xm23Pkg::opRrc, xm23Pkg::opSwpb, xm23Pkg::opSxt};
		xm23Pkg::opcodeT op;
		logic            rc, wb;
		for (int i = 0; i < 44; i++) begin
			op = ops[i % 11];
			rc = (op <= xm23Pkg::opBis) ? 1'(nextRand()) : 1'b0;	// Only two-operand forms
			wb = (op == xm23Pkg::opSwpb || op == xm23Pkg::opSxt) ? 1'b0 : 1'(nextRand());
			runOp(op, rc, wb, 3'(nextRand()), 3'(nextRand()), 8'd0);
		end
		endTest("logic and moves");
	endtask

	task automatic testForwarding();
		logic [15:0] startA, startB, chained;
		startA = 16'(nextRand());
		startB = 16'(nextRand());
		for (int spaced = 0; spaced < 2; spaced++) begin
			loadReg(3'd1, startA);
			loadReg(3'd2, startB);
			for (int k = 0; k < 4; k++) begin
				if (spaced == 0)
					issueOp(xm23Pkg::opAdd, 1'b0, 1'b0, 3'(1 + k % 2), 3'(2 - k % 2), 8'd0);
				else
					runOp(xm23Pkg::opAdd, 1'b0, 1'b0, 3'(1 + k % 2), 3'(2 - k % 2), 8'd0);
			end
			if (spaced == 0) begin
				stopIssue();
				checkRetires(4);
				chained = lastValue;
			end else begin
				compareWord("spaced chain result", chained, lastValue);
			end
		end
		endTest("forwarding");
	endtask

	task automatic testFlags();
		runOp(xm23Pkg::opSetcc, 1'b0, 1'b0, 3'd0, 3'd0, 8'h0F);
		runOp(xm23Pkg::opClrcc, 1'b0, 1'b0, 3'd0, 3'd0, 8'h0A);
		runOp(xm23Pkg::opAddc, 1'b0, 1'b0, 3'd3, 3'd4, 8'd0);
		runOp(xm23Pkg::opClrcc, 1'b0, 1'b0, 3'd0, 3'd0, 8'h01);
		runOp(xm23Pkg::opAddc, 1'b1, 1'b0, 3'd1, 3'd5, 8'd0);
		issueOp(xm23Pkg::opSetcc, 1'b0, 1'b0, 3'd0, 3'd0, 8'h01);	// New carry used at once
		issueOp(xm23Pkg::opAddc, 1'b0, 1'b1, 3'd6, 3'd7, 8'd0);
		stopIssue();
		checkRetires(2);
		endTest("flags");
	endtask

	task automatic testFaults();
		runOp(xm23Pkg::opReserved, 1'b0, 1'b0, 3'd0, 3'd1, 8'd0);
		runOp(xm23Pkg::opLd, 1'b0, 1'b0, 3'd2, 3'd3, 8'd0);
		runOp(xm23Pkg::opBl, 1'b0, 1'b0, 3'd0, 3'd4, 8'd0);
		runOp(xm23Pkg::opDadd, 1'b0, 1'b0, 3'd5, 3'd6, 8'd0);
		for (int r = 0; r < 8; r++)
			runOp(xm23Pkg::opMov, 1'b0, 1'b0, 3'(r), 3'(r), 8'd0);	// Read-back
		endTest("faults");
	endtask

	initial begin
		instr = 16'h0000;
		instrValid = 1'b0;
		reset = 1'b1;
		repeat (2) @(negedge Clock);
		reset = 1'b0;
		testLoads();
		testArith();
		testLogic();
		testForwarding();
		testFlags();
		testFaults();
		if (gotQ.size() != 0) begin
			errors++;
			$display("The core retired %0d instructions that were never issued", gotQ.size());
		end
		$display("Ran %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== project.f ====
common/xm23Pkg.sv
decode/instructionDecoder.sv
execute/registerFile.sv
execute/executeUnit.sv
rtl/resultStage.sv
rtl/xm23Core.sv
testbench/xm23CoreAssertions.sv
testbench/xm23CoreTb.sv
